// File: logic/watch_config.svh
`ifndef WATCH_CONFIG_SVH
`define WATCH_CONFIG_SVH

// cycles of mode held high that count as a long press.
`define WATCH_LONG_PRESS 3

// highest value of each field before it wraps to zero.
`define WATCH_MAX_SEC 59
`define WATCH_MAX_MIN 59

// one storage unit per mode: time, stopwatch and alarm.
`define WATCH_NUM_UNITS 3

`endif

// File: logic/watch_ctrl_pkg.sv
`default_nettype none

package watch_ctrl_pkg;

  // the group order follows the mode button cycle.
  typedef enum logic [3:0] {
    TIME_DISP   = 4'd0,
    TIME_SETMIN = 4'd1,
    TIME_SETSEC = 4'd2,
    STW_DISP    = 4'd3,
    STW_SETMIN  = 4'd4,
    STW_SETSEC  = 4'd5,
    STW_START   = 4'd6,
    STW_PAUSE   = 4'd7,
    ALM_DISP    = 4'd8,
    ALM_SETMIN  = 4'd9,
    ALM_SETSEC  = 4'd10
  } mode_state_e;

  typedef enum logic {
    FIELD_MIN = 1'b0,
    FIELD_SEC = 1'b1
  } set_field_e;

endpackage

`default_nettype wire

// File: logic/watch_time_pkg.sv
`default_nettype none

package watch_time_pkg;

  typedef struct packed {
    logic [5:0] min;
    logic [5:0] sec;
  } mmss_t;

  // also the index into the per-unit value arrays.
  typedef enum logic [1:0] {
    UNIT_TIME = 2'd0,
    UNIT_STW  = 2'd1,
    UNIT_ALM  = 2'd2
  } unit_idx_e;

endpackage

`default_nettype wire

// File: logic/unit_ctrl_if.sv
`default_nettype none

interface unit_ctrl_if;

  logic                      count_en;  // advance live on tick.
  logic                      snap;      // load edit from live.
  logic                      set_inc;   // step one field of edit.
  watch_ctrl_pkg::set_field_e set_field;
  logic                      commit;    // load live from edit.

  modport ctrl (output count_en, snap, set_inc, set_field, commit);
  modport unit (input count_en, snap, set_inc, set_field, commit);

endinterface

`default_nettype wire

// File: logic/mode_fsm.sv
`default_nettype none
`include "watch_config.svh"

module mode_fsm (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         mode,
  input  wire                         switch,
  output watch_ctrl_pkg::mode_state_e state,
  output logic                        alarm_enable,
  unit_ctrl_if.ctrl                   ctrl [`WATCH_NUM_UNITS]
);

  localparam int PCW = $clog2(`WATCH_LONG_PRESS + 1);

  logic [PCW-1:0]              press_count;
  logic                        mode_d;
  logic                        long_press;
  logic                        short_press;
  watch_ctrl_pkg::mode_state_e state_next;
  watch_time_pkg::unit_idx_e   grp;
  watch_ctrl_pkg::set_field_e  field;
  logic                        snap_req;
  logic                        commit_req;
  logic                        set_act;
  logic                        stw_run;
  logic                        alm_toggle;
  logic [`WATCH_NUM_UNITS-1:0] count_en_u;
  logic [`WATCH_NUM_UNITS-1:0] snap_u;
  logic [`WATCH_NUM_UNITS-1:0] commit_u;
  logic [`WATCH_NUM_UNITS-1:0] inc_u;

  // The counter saturates so that a held button gives a single long press.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      press_count <= '0;
      mode_d      <= 1'b0;
    end
    else
    begin
      mode_d <= mode;
      if (!mode)
        press_count <= '0;
      else if (press_count != PCW'(`WATCH_LONG_PRESS))
        press_count <= press_count + 1'b1;
    end
  end

  // fires in the third consecutive cycle with mode high.
  assign long_press  = mode && (press_count == PCW'(`WATCH_LONG_PRESS - 1));
  assign short_press = !mode && mode_d && (press_count < PCW'(`WATCH_LONG_PRESS));

  always_comb
  begin
    state_next = state;
    grp        = watch_time_pkg::UNIT_TIME;
    field      = watch_ctrl_pkg::FIELD_MIN;
    snap_req   = 1'b0;
    commit_req = 1'b0;
    set_act    = 1'b0;
    stw_run    = 1'b0;
    alm_toggle = 1'b0;
    case (state)
      watch_ctrl_pkg::TIME_DISP:
      begin
        if (long_press)
        begin
          state_next = watch_ctrl_pkg::TIME_SETMIN;
          snap_req   = 1'b1;
        end
        else if (short_press)
          state_next = watch_ctrl_pkg::STW_DISP;
      end
      watch_ctrl_pkg::TIME_SETMIN, watch_ctrl_pkg::TIME_SETSEC:
      begin
        set_act = 1'b1;
        if (state == watch_ctrl_pkg::TIME_SETSEC)
          field = watch_ctrl_pkg::FIELD_SEC;
        if (short_press)
          state_next = (state == watch_ctrl_pkg::TIME_SETMIN) ?
                       watch_ctrl_pkg::TIME_SETSEC : watch_ctrl_pkg::TIME_SETMIN;
        else if (long_press)
        begin
          state_next = watch_ctrl_pkg::TIME_DISP;
          commit_req = 1'b1;
        end
      end
      watch_ctrl_pkg::STW_DISP:
      begin
        grp = watch_time_pkg::UNIT_STW;
        if (long_press)
        begin
          state_next = watch_ctrl_pkg::STW_SETMIN;
          snap_req   = 1'b1;
        end
        else if (short_press)
          state_next = watch_ctrl_pkg::ALM_DISP;
        else if (switch)
        begin
          state_next = watch_ctrl_pkg::STW_START;
          stw_run    = 1'b1;  // the starting cycle already counts.
        end
      end
      watch_ctrl_pkg::STW_SETMIN, watch_ctrl_pkg::STW_SETSEC:
      begin
        grp     = watch_time_pkg::UNIT_STW;
        set_act = 1'b1;
        if (state == watch_ctrl_pkg::STW_SETSEC)
          field = watch_ctrl_pkg::FIELD_SEC;
        if (short_press)
          state_next = (state == watch_ctrl_pkg::STW_SETMIN) ?
                       watch_ctrl_pkg::STW_SETSEC : watch_ctrl_pkg::STW_SETMIN;
        else if (long_press)
        begin
          state_next = watch_ctrl_pkg::STW_DISP;
          commit_req = 1'b1;
        end
      end
      watch_ctrl_pkg::STW_START:
      begin
        grp     = watch_time_pkg::UNIT_STW;
        stw_run = 1'b1;
        if (switch)
          state_next = watch_ctrl_pkg::STW_PAUSE;
      end
      watch_ctrl_pkg::STW_PAUSE:
      begin
        grp = watch_time_pkg::UNIT_STW;
        if (switch)
          state_next = watch_ctrl_pkg::STW_START;
        else if (long_press)
        begin
          // edit still holds the snapped value, so this is a reset to it.
          state_next = watch_ctrl_pkg::STW_DISP;
          commit_req = 1'b1;
        end
      end
      watch_ctrl_pkg::ALM_DISP:
      begin
        grp = watch_time_pkg::UNIT_ALM;
        if (long_press)
        begin
          state_next = watch_ctrl_pkg::ALM_SETMIN;
          snap_req   = 1'b1;
        end
        else if (short_press)
          state_next = watch_ctrl_pkg::TIME_DISP;
        else if (switch)
          alm_toggle = 1'b1;
      end
      watch_ctrl_pkg::ALM_SETMIN, watch_ctrl_pkg::ALM_SETSEC:
      begin
        grp     = watch_time_pkg::UNIT_ALM;
        set_act = 1'b1;
        if (state == watch_ctrl_pkg::ALM_SETSEC)
          field = watch_ctrl_pkg::FIELD_SEC;
        if (short_press)
          state_next = (state == watch_ctrl_pkg::ALM_SETMIN) ?
                       watch_ctrl_pkg::ALM_SETSEC : watch_ctrl_pkg::ALM_SETMIN;
        else if (long_press)
        begin
          state_next = watch_ctrl_pkg::ALM_DISP;
          commit_req = 1'b1;
        end
      end
      default: state_next = watch_ctrl_pkg::TIME_DISP;
    endcase
  end

  // only the unit of the current mode group sees the edit pulses.
  always_comb
  begin
    snap_u      = '0;
    commit_u    = '0;
    inc_u       = '0;
    snap_u[grp]   = snap_req;
    commit_u[grp] = commit_req;
    inc_u[grp]    = set_act && switch;
    count_en_u    = '0;
    count_en_u[watch_time_pkg::UNIT_TIME] = 1'b1;  // the clock never stops.
    count_en_u[watch_time_pkg::UNIT_STW]  = stw_run;
  end

  for (genvar i = 0; i < `WATCH_NUM_UNITS; i++)
  begin : g_ctrl
    assign ctrl[i].count_en  = count_en_u[i];
    assign ctrl[i].snap      = snap_u[i];
    assign ctrl[i].set_inc   = inc_u[i];
    assign ctrl[i].set_field = field;
    assign ctrl[i].commit    = commit_u[i];
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= watch_ctrl_pkg::TIME_DISP;
      alarm_enable <= 1'b0;
    end
    else
    begin
      state        <= state_next;
      alarm_enable <= alarm_enable ^ alm_toggle;
    end
  end

endmodule

`default_nettype wire

// File: logic/mmss_unit.sv
`default_nettype none
`include "watch_config.svh"

module mmss_unit (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   tick,
  unit_ctrl_if.unit             ctrl,
  output watch_time_pkg::mmss_t live,
  output watch_time_pkg::mmss_t edit
);

  localparam logic [5:0] MAX_SEC = 6'(`WATCH_MAX_SEC);
  localparam logic [5:0] MAX_MIN = 6'(`WATCH_MAX_MIN);

  watch_time_pkg::mmss_t live_next;
  watch_time_pkg::mmss_t edit_next;

  function automatic logic [5:0] wrap_inc(input logic [5:0] v, input logic [5:0] max_v);
    return (v == max_v) ? 6'd0 : v + 6'd1;
  endfunction

  // A commit wins over counting, so a tick on that edge is lost.
  always_comb
  begin
    live_next = live;
    if (ctrl.commit)
      live_next = edit;
    else if (ctrl.count_en && tick)
    begin
      live_next.sec = wrap_inc(live.sec, MAX_SEC);
      if (live.sec == MAX_SEC)
        live_next.min = wrap_inc(live.min, MAX_MIN);  // carry out of seconds.
    end
  end

  // edit fields wrap on their own with no carry.
  always_comb
  begin
    edit_next = edit;
    if (ctrl.snap)
      edit_next = live;
    else if (ctrl.set_inc)
    begin
      if (ctrl.set_field == watch_ctrl_pkg::FIELD_SEC)
        edit_next.sec = wrap_inc(edit.sec, MAX_SEC);
      else
        edit_next.min = wrap_inc(edit.min, MAX_MIN);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      live <= '0;
      edit <= '0;
    end
    else
    begin
      live <= live_next;
      edit <= edit_next;
    end
  end

endmodule

`default_nettype wire

// File: logic/display_alarm.sv
`default_nettype none
`include "watch_config.svh"

module display_alarm (
  input  wire watch_ctrl_pkg::mode_state_e state,
  input  wire                              alarm_enable,
  input  wire watch_time_pkg::mmss_t       live [`WATCH_NUM_UNITS],
  input  wire watch_time_pkg::mmss_t       edit [`WATCH_NUM_UNITS],
  output watch_time_pkg::mmss_t            disp_value,
  output logic                             setting,
  output logic                             alarm_ring
);

  watch_time_pkg::unit_idx_e grp;

  always_comb
  begin
    grp     = watch_time_pkg::UNIT_TIME;
    setting = 1'b0;
    case (state)
      watch_ctrl_pkg::TIME_SETMIN, watch_ctrl_pkg::TIME_SETSEC:
        setting = 1'b1;
      watch_ctrl_pkg::STW_DISP, watch_ctrl_pkg::STW_START, watch_ctrl_pkg::STW_PAUSE:
        grp = watch_time_pkg::UNIT_STW;
      watch_ctrl_pkg::STW_SETMIN, watch_ctrl_pkg::STW_SETSEC:
      begin
        grp     = watch_time_pkg::UNIT_STW;
        setting = 1'b1;
      end
      watch_ctrl_pkg::ALM_DISP:
        grp = watch_time_pkg::UNIT_ALM;
      watch_ctrl_pkg::ALM_SETMIN, watch_ctrl_pkg::ALM_SETSEC:
      begin
        grp     = watch_time_pkg::UNIT_ALM;
        setting = 1'b1;
      end
      default: grp = watch_time_pkg::UNIT_TIME;
    endcase
  end

  // while setting, the display shows the value being edited.
  assign disp_value = setting ? edit[grp] : live[grp];

  assign alarm_ring = alarm_enable &&
                      (live[watch_time_pkg::UNIT_TIME] == live[watch_time_pkg::UNIT_ALM]);

endmodule

`default_nettype wire

// File: logic/watch_top.sv
`default_nettype none
`include "watch_config.svh"

module watch_top (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         mode,
  input  wire                         switch,
  input  wire                         tick,
  output watch_ctrl_pkg::mode_state_e state_led,
  output logic                        setting,
  output watch_time_pkg::mmss_t       disp_value,
  output logic                        alarm_enable,
  output logic                        alarm_ring
);

  unit_ctrl_if           ctrl_bus [`WATCH_NUM_UNITS] ();
  watch_time_pkg::mmss_t live_val [`WATCH_NUM_UNITS];
  watch_time_pkg::mmss_t edit_val [`WATCH_NUM_UNITS];

  mode_fsm mode_fsm_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .mode         (mode),
    .switch       (switch),
    .state        (state_led),
    .alarm_enable (alarm_enable),
    .ctrl         (ctrl_bus)
  );

  // one unit each for time, stopwatch and alarm.
  for (genvar i = 0; i < `WATCH_NUM_UNITS; i++)
  begin : g_unit
    localparam watch_time_pkg::unit_idx_e IDX = watch_time_pkg::unit_idx_e'(i);

    mmss_unit mmss_unit_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .tick  (tick),
      .ctrl  (ctrl_bus[i]),
      .live  (live_val[IDX]),
      .edit  (edit_val[IDX])
    );
  end

  display_alarm display_alarm_inst (
    .state        (state_led),
    .alarm_enable (alarm_enable),
    .live         (live_val),
    .edit         (edit_val),
    .disp_value   (disp_value),
    .setting      (setting),
    .alarm_ring   (alarm_ring)
  );

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 100
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: sim/watch_tb.sv
`default_nettype none
`include "watch_config.svh"

module watch_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_CYCLES   = 4000;
  localparam int DRIVE_DELAY  = 1;
  localparam int LONG         = `WATCH_LONG_PRESS;
  localparam logic [5:0] MAX_SEC = 6'(`WATCH_MAX_SEC);
  localparam logic [5:0] MAX_MIN = 6'(`WATCH_MAX_MIN);

  // two short presses reach ALM_DISP and a switch pulse arms the alarm with no tick.
  // time and alarm then both read 00:00, so the ring must go high.
  localparam int                    OPEN_CYCLES = 5;
  localparam logic [OPEN_CYCLES-1:0] OPEN_MODE   = 5'b00101;
  localparam logic [OPEN_CYCLES-1:0] OPEN_SWITCH = 5'b10000;

  logic clk;
  logic rst_n;
  logic mode;
  logic switch;
  logic tick;
  watch_ctrl_pkg::mode_state_e state_led;
  logic setting;
  watch_time_pkg::mmss_t disp_value;
  logic alarm_enable;
  logic alarm_ring;

  integer seed = 37466;
  int     mode_left;  // cycles of the current press still to hold.

  // reference model registers.
  watch_ctrl_pkg::mode_state_e m_state;
  int                          m_press;
  logic                        m_mode_d;
  logic                        m_alarm_en;
  watch_time_pkg::mmss_t       m_live [`WATCH_NUM_UNITS];
  watch_time_pkg::mmss_t       m_edit [`WATCH_NUM_UNITS];

  tb_clock_gen #(.PERIOD(CLK_PERIOD)) tb_clock_gen_inst (.clk(clk));

  watch_top watch_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .mode         (mode),
    .switch       (switch),
    .tick         (tick),
    .state_led    (state_led),
    .setting      (setting),
    .disp_value   (disp_value),
    .alarm_enable (alarm_enable),
    .alarm_ring   (alarm_ring)
  );

  function automatic watch_time_pkg::unit_idx_e group_of(input watch_ctrl_pkg::mode_state_e s);
    if (s inside {watch_ctrl_pkg::STW_DISP, watch_ctrl_pkg::STW_SETMIN, watch_ctrl_pkg::STW_SETSEC,
                  watch_ctrl_pkg::STW_START, watch_ctrl_pkg::STW_PAUSE})
      return watch_time_pkg::UNIT_STW;
    if (s inside {watch_ctrl_pkg::ALM_DISP, watch_ctrl_pkg::ALM_SETMIN, watch_ctrl_pkg::ALM_SETSEC})
      return watch_time_pkg::UNIT_ALM;
    return watch_time_pkg::UNIT_TIME;
  endfunction

  function automatic logic in_set(input watch_ctrl_pkg::mode_state_e s);
    return s inside {watch_ctrl_pkg::TIME_SETMIN, watch_ctrl_pkg::TIME_SETSEC,
                     watch_ctrl_pkg::STW_SETMIN, watch_ctrl_pkg::STW_SETSEC,
                     watch_ctrl_pkg::ALM_SETMIN, watch_ctrl_pkg::ALM_SETSEC};
  endfunction

  // kind 0 is the display state, 1 sets minutes, 2 sets seconds.
  function automatic watch_ctrl_pkg::mode_state_e state_of(input watch_time_pkg::unit_idx_e g,
                                                           input int kind);
    case (g)
      watch_time_pkg::UNIT_STW:
        return (kind == 0) ? watch_ctrl_pkg::STW_DISP :
               (kind == 1) ? watch_ctrl_pkg::STW_SETMIN : watch_ctrl_pkg::STW_SETSEC;
      watch_time_pkg::UNIT_ALM:
        return (kind == 0) ? watch_ctrl_pkg::ALM_DISP :
               (kind == 1) ? watch_ctrl_pkg::ALM_SETMIN : watch_ctrl_pkg::ALM_SETSEC;
      default:
        return (kind == 0) ? watch_ctrl_pkg::TIME_DISP :
               (kind == 1) ? watch_ctrl_pkg::TIME_SETMIN : watch_ctrl_pkg::TIME_SETSEC;
    endcase
  endfunction

  function automatic watch_time_pkg::mmss_t advance_second(input watch_time_pkg::mmss_t v);
    watch_time_pkg::mmss_t r;
    r = v;
    if (v.sec == MAX_SEC)
    begin
      r.sec = 6'd0;
      r.min = (v.min == MAX_MIN) ? 6'd0 : v.min + 6'd1;
    end
    else
      r.sec = v.sec + 6'd1;
    return r;
  endfunction

  task automatic model_step(input logic m, input logic sw, input logic tk);
    watch_ctrl_pkg::mode_state_e nxt;
    watch_time_pkg::unit_idx_e   grp;
    watch_time_pkg::mmss_t       old_live [`WATCH_NUM_UNITS];
    logic lp;
    logic sp;
    logic set_st;
    logic sec_field;
    logic snap;
    logic commit;
    logic run;
    logic tog;
    grp       = group_of(m_state);
    set_st    = in_set(m_state);
    sec_field = (m_state == state_of(grp, 2));
    lp        = m && (m_press == LONG - 1);
    sp        = !m && m_mode_d && (m_press < LONG);
    nxt       = m_state;
    snap      = 1'b0;
    commit    = 1'b0;
    tog       = 1'b0;
    run       = (m_state == watch_ctrl_pkg::STW_START);
    if (m_state == state_of(grp, 0))
    begin
      if (lp)
      begin
        nxt  = state_of(grp, 1);
        snap = 1'b1;
      end
      else if (sp)
        nxt = state_of(watch_time_pkg::unit_idx_e'((int'(grp) + 1) % 3), 0);
      else if (sw && grp == watch_time_pkg::UNIT_STW)
      begin
        nxt = watch_ctrl_pkg::STW_START;
        run = 1'b1;
      end
      else if (sw && grp == watch_time_pkg::UNIT_ALM)
        tog = 1'b1;
    end
    else if (m_state == watch_ctrl_pkg::STW_START)
    begin
      if (sw)
        nxt = watch_ctrl_pkg::STW_PAUSE;
    end
    else if (m_state == watch_ctrl_pkg::STW_PAUSE)
    begin
      if (sw)
        nxt = watch_ctrl_pkg::STW_START;
      else if (lp)
      begin
        nxt    = watch_ctrl_pkg::STW_DISP;
        commit = 1'b1;
      end
    end
    else if (sp)
      nxt = state_of(grp, sec_field ? 1 : 2);  // swap the field.
    else if (lp)
    begin
      nxt    = state_of(grp, 0);
      commit = 1'b1;
    end

    old_live = m_live;
    for (int u = 0; u < `WATCH_NUM_UNITS; u++)
    begin
      if (commit && u == int'(grp))
        m_live[u] = m_edit[u];
      else if (tk && (u == 0 || (u == 1 && run)))
        m_live[u] = advance_second(m_live[u]);
      if (snap && u == int'(grp))
        m_edit[u] = old_live[u];
      else if (set_st && sw && u == int'(grp))
      begin
        if (sec_field)
          m_edit[u].sec = (m_edit[u].sec == MAX_SEC) ? 6'd0 : m_edit[u].sec + 6'd1;
        else
          m_edit[u].min = (m_edit[u].min == MAX_MIN) ? 6'd0 : m_edit[u].min + 6'd1;
      end
    end

    m_alarm_en = m_alarm_en ^ tog;
    if (!m)
      m_press = 0;
    else if (m_press < LONG)
      m_press = m_press + 1;
    m_mode_d = m;
    m_state  = nxt;
  endtask

  task automatic compare_value(input string name, input int expected, input int actual);
    assert (expected == actual)
    else
    begin
      $display("FAIL %s expected %0d actual %0d", name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic check_outputs();
    watch_time_pkg::unit_idx_e grp;
    watch_time_pkg::mmss_t     exp_disp;
    logic                      exp_set;
    grp      = group_of(m_state);
    exp_set  = in_set(m_state);
    exp_disp = exp_set ? m_edit[grp] : m_live[grp];
    compare_value("state_led", int'(m_state), int'(state_led));
    compare_value("setting", int'(exp_set), int'(setting));
    compare_value("disp_value", int'(exp_disp), int'(disp_value));
    compare_value("alarm_enable", int'(m_alarm_en), int'(alarm_enable));
    compare_value("alarm_ring", int'(m_alarm_en && (m_live[0] == m_live[2])), int'(alarm_ring));
  endtask

  // presses last 1 to 5 cycles with at least one idle cycle between them.
  task automatic drive_inputs(input int n);
    int r;
    r = $random(seed);
    if (n < OPEN_CYCLES)
    begin
      mode   = OPEN_MODE[n];
      switch = OPEN_SWITCH[n];
      tick   = 1'b0;
    end
    else
    begin
      if (mode_left > 0)
      begin
        mode      = 1'b1;
        mode_left = mode_left - 1;
      end
      else
      begin
        mode = 1'b0;
        if (r[2:0] == 3'd0)
          mode_left = 1 + int'(r[15:8]) % 5;
      end
      switch = (r[18:16] == 3'd0);
      tick   = (r[21:20] == 2'd0);  // about one cycle in four.
    end
  endtask

  initial
  begin
    rst_n      = 1'b0;
    mode       = 1'b0;
    switch     = 1'b0;
    tick       = 1'b0;
    mode_left  = 0;
    m_state    = watch_ctrl_pkg::TIME_DISP;
    m_press    = 0;
    m_mode_d   = 1'b0;
    m_alarm_en = 1'b0;
    for (int u = 0; u < `WATCH_NUM_UNITS; u++)
    begin
      m_live[u] = '0;
      m_edit[u] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    drive_inputs(0);
    check_outputs();
    for (int i = 0; i < NUM_CYCLES; i++)
    begin
      @(posedge clk);
      model_step(mode, switch, tick);
      #DRIVE_DELAY;
      drive_inputs(i + 1);
      @(negedge clk);
      check_outputs();
    end
    $display("TB PASSED");
    $finish;
  end

  initial
  begin
    #((RESET_CYCLES + NUM_CYCLES + 20) * CLK_PERIOD);
    $display("timeout: the random test did not finish in the expected time");
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/watch_ctrl_pkg.sv
logic/watch_time_pkg.sv
logic/unit_ctrl_if.sv
logic/mode_fsm.sv
logic/mmss_unit.sv
logic/display_alarm.sv
logic/watch_top.sv
sim/tb_clock_gen.sv
sim/watch_tb.sv

// File: run.sh
#!/bin/sh
# Builds the watch testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
  -f sources.f --top-module watch_tb -o watch_sim > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/watch_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
  exit 0
else
  echo "pass line not found in sim.log"
  exit 1
fi
